/* source/dsp_pkg.sv */
package dsp_pkg;

    // ADC sample codes
    localparam int CODE_W = 8;

    // Feed-forward equalizer
    localparam int FFE_LEN     = 3;
    localparam int WEIGHT_W    = 6;
    localparam int FFE_SHIFT_W = 3;
    localparam int EST_W       = 10;

    // Slicer
    localparam int THRESH_W = 10;

    // Channel estimate
    localparam int CHAN_LEN     = 2;
    localparam int CHAN_W       = 8;
    localparam int CHAN_SHIFT_W = 2;

    localparam int ERR_W = 10;

    // Cycles from start or config write until outputs carry only new data
    localparam int PIPE_FILL = 3;

    // Host write port, wide enough for the widest field
    localparam int CFG_TAP_W  = 2;
    localparam int CFG_DATA_W = 10;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        RUN
    } ctrl_state_t;

    typedef enum logic [2:0] {
        CFG_WEIGHT     = 3'd0,
        CFG_DISABLE    = 3'd1,
        CFG_FFE_SHIFT  = 3'd2,
        CFG_THRESH     = 3'd3,
        CFG_CHAN_TAP   = 3'd4,
        CFG_CHAN_SHIFT = 3'd5
    } cfg_addr_t;

endpackage

/* source/code_delay_line.sv */
`timescale 1ns/1ps

module code_delay_line #(
    parameter int NUM_LANES = 4,
    parameter int WIDTH     = 8,
    parameter int DEPTH     = 1
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic [NUM_LANES-1:0][WIDTH-1:0]  data_i,
    output logic [NUM_LANES-1:0][WIDTH-1:0]  data_o
);

    // One full lane word per stage
    logic [NUM_LANES-1:0][WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DEPTH-1];

    initial begin
        assert (DEPTH >= 1)
            else $fatal(1, "code_delay_line needs DEPTH of at least 1, got %0d", DEPTH);
    end

endmodule

/* source/ffe_slicer.sv */
`timescale 1ns/1ps

module ffe_slicer #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                        clk,
    input  logic                                                        reset_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::CODE_W-1:0]                   codes_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::FFE_LEN-1:0][dsp_pkg::WEIGHT_W-1:0] weights_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::FFE_LEN-1:0]                  disable_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::FFE_SHIFT_W-1:0]              ffe_shift_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::THRESH_W-1:0]                 thresh_i,
    output logic [NUM_LANES-1:0]                                        bits_o
);
    import dsp_pkg::*;

    localparam int PROD_W = CODE_W + WEIGHT_W;
    localparam int SUM_W  = PROD_W + $clog2(FFE_LEN);

    logic [NUM_LANES-1:0][CODE_W-1:0]   prev_codes_q;
    // Lane 0 is the oldest sample of a word
    logic [2*NUM_LANES-1:0][CODE_W-1:0] history;
    logic [NUM_LANES-1:0]               decision;

    assign history = {codes_i, prev_codes_q};

    always_comb begin
        logic signed [PROD_W-1:0] prod;
        logic signed [SUM_W-1:0]  acc;
        logic signed [SUM_W-1:0]  shifted;
        logic signed [EST_W-1:0]  est;
        for (int l = 0; l < NUM_LANES; l++) begin
            acc = '0;
            // Tap k reaches k samples back, into the previous word if needed
            for (int k = 0; k < FFE_LEN; k++) begin
                prod = $signed(history[NUM_LANES+l-k]) * $signed(weights_i[l][k]);
                if (!disable_i[l][k]) begin
                    acc = acc + prod;
                end
            end
            shifted = acc >>> ffe_shift_i[l];
            est = shifted[EST_W-1:0];
            decision[l] = (est >= $signed(thresh_i[l]));
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_codes_q <= '0;
            bits_o       <= '0;
        end else begin
            prev_codes_q <= codes_i;
            bits_o       <= decision;
        end
    end

    // Downstream channel filter relies on clean bits after reset
    a_bits_clear_after_reset: assert property (
        @(posedge clk) reset_i |=> (bits_o == '0)
    ) else $error("ffe_slicer: bits_o not cleared after reset");

endmodule

/* source/channel_error.sv */
`timescale 1ns/1ps

module channel_error #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                       clk,
    input  logic                                                       reset_i,
    input  logic [NUM_LANES-1:0]                                       bits_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::CODE_W-1:0]                  codes_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::CHAN_LEN-1:0][dsp_pkg::CHAN_W-1:0] chan_taps_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::CHAN_SHIFT_W-1:0]            chan_shift_i,
    output logic [NUM_LANES-1:0][dsp_pkg::ERR_W-1:0]                   error_o
);
    import dsp_pkg::*;

    // Extra bit keeps the negated most negative tap in range
    localparam int SUM_W = CHAN_W + $clog2(CHAN_LEN) + 1;

    logic [NUM_LANES-1:0]              prev_bits_q;
    logic [2*NUM_LANES-1:0]            bit_hist;
    logic [NUM_LANES-1:0][ERR_W-1:0]   err_d;

    assign bit_hist = {bits_i, prev_bits_q};

    always_comb begin
        logic signed [CHAN_W-1:0] tap;
        logic signed [SUM_W-1:0]  acc;
        logic signed [SUM_W-1:0]  expected;
        logic signed [ERR_W-1:0]  diff;
        for (int l = 0; l < NUM_LANES; l++) begin
            acc = '0;
            for (int k = 0; k < CHAN_LEN; k++) begin
                tap = $signed(chan_taps_i[l][k]);
                // Bit 1 maps to +tap, bit 0 to -tap
                if (bit_hist[NUM_LANES+l-k]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            expected = acc >>> chan_shift_i[l];
            diff = expected - $signed(codes_i[l]);
            err_d[l] = diff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_bits_q <= '0;
            error_o     <= '0;
        end else begin
            prev_bits_q <= bits_i;
            error_o     <= err_d;
        end
    end

endmodule

/* source/config_regs.sv */
`timescale 1ns/1ps

module config_regs #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                        clk,
    input  logic                                                        reset_i,
    input  logic                                                        wr_i,
    input  dsp_pkg::cfg_addr_t                                          addr_i,
    input  logic [$clog2(NUM_LANES)-1:0]                                lane_i,
    input  logic [dsp_pkg::CFG_TAP_W-1:0]                               tap_i,
    input  logic [dsp_pkg::CFG_DATA_W-1:0]                              data_i,
    output logic [NUM_LANES-1:0][dsp_pkg::FFE_LEN-1:0][dsp_pkg::WEIGHT_W-1:0] weights_o,
    output logic [NUM_LANES-1:0][dsp_pkg::FFE_LEN-1:0]                  disable_o,
    output logic [NUM_LANES-1:0][dsp_pkg::FFE_SHIFT_W-1:0]              ffe_shift_o,
    output logic [NUM_LANES-1:0][dsp_pkg::THRESH_W-1:0]                 thresh_o,
    output logic [NUM_LANES-1:0][dsp_pkg::CHAN_LEN-1:0][dsp_pkg::CHAN_W-1:0] chan_taps_o,
    output logic [NUM_LANES-1:0][dsp_pkg::CHAN_SHIFT_W-1:0]             chan_shift_o
);
    import dsp_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            weights_o    <= '0;
            disable_o    <= '0;
            ffe_shift_o  <= '0;
            thresh_o     <= '0;
            chan_taps_o  <= '0;
            chan_shift_o <= '0;
        end else if (wr_i) begin
            case (addr_i)
                CFG_WEIGHT:     weights_o[lane_i][tap_i]   <= data_i[WEIGHT_W-1:0];
                CFG_DISABLE:    disable_o[lane_i][tap_i]   <= data_i[0];
                CFG_FFE_SHIFT:  ffe_shift_o[lane_i]        <= data_i[FFE_SHIFT_W-1:0];
                CFG_THRESH:     thresh_o[lane_i]           <= data_i[THRESH_W-1:0];
                CFG_CHAN_TAP:   chan_taps_o[lane_i][tap_i] <= data_i[CHAN_W-1:0];
                CFG_CHAN_SHIFT: chan_shift_o[lane_i]       <= data_i[CHAN_SHIFT_W-1:0];
                default: ;
            endcase
        end
    end

    // Tap index limit depends on which table is addressed
    a_tap_in_range: assert property (
        @(posedge clk) disable iff (reset_i)
        wr_i |-> ((addr_i == CFG_CHAN_TAP) ? (tap_i < CHAN_LEN) : (tap_i < FFE_LEN))
    ) else $error("config_regs: tap index %0d out of range for %s", tap_i, addr_i.name());

endmodule

/* source/fill_counter.sv */
`timescale 1ns/1ps

module fill_counter (
    input  logic clk,
    input  logic reset_i,
    input  logic load_i,
    output logic done_o
);
    import dsp_pkg::*;

    localparam int CNT_W = $clog2(PIPE_FILL + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= CNT_W'(PIPE_FILL - 1);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Holds at zero until the next load
    assign done_o = (count_q == '0);

endmodule

/* source/startup_fsm.sv */
`timescale 1ns/1ps

module startup_fsm (
    input  logic clk,
    input  logic reset_i,
    input  logic start_i,
    input  logic cfg_wr_i,
    input  logic fill_done_i,
    output logic fill_load_o,
    output logic valid_o
);
    import dsp_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_comb begin
        state_d     = state_q;
        fill_load_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d     = FILL;
                    fill_load_o = 1'b1;
                end
            end
            FILL: begin
                // A write while filling restarts the count
                if (cfg_wr_i) begin
                    fill_load_o = 1'b1;
                end else if (fill_done_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (cfg_wr_i) begin
                    state_d     = FILL;
                    fill_load_o = 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign valid_o = (state_q == RUN);

    a_valid_from_fill: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(valid_o) |-> ($past(state_q) == FILL)
    ) else $error("startup_fsm: valid_o rose without passing through FILL");

endmodule

/* source/dsp_datapath_top.sv */
`timescale 1ns/1ps

module dsp_datapath_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  logic [NUM_LANES-1:0][dsp_pkg::CODE_W-1:0]  adc_codes_i,
    input  logic                                       start_i,
    input  logic                                       cfg_wr_i,
    input  dsp_pkg::cfg_addr_t                         cfg_addr_i,
    input  logic [$clog2(NUM_LANES)-1:0]               cfg_lane_i,
    input  logic [dsp_pkg::CFG_TAP_W-1:0]              cfg_tap_i,
    input  logic [dsp_pkg::CFG_DATA_W-1:0]             cfg_data_i,
    output logic [NUM_LANES-1:0]                       bits_o,
    output logic [NUM_LANES-1:0][dsp_pkg::ERR_W-1:0]   error_o,
    output logic                                       valid_o
);
    import dsp_pkg::*;

    logic [NUM_LANES-1:0][FFE_LEN-1:0][WEIGHT_W-1:0] weights;
    logic [NUM_LANES-1:0][FFE_LEN-1:0]               ffe_disable;
    logic [NUM_LANES-1:0][FFE_SHIFT_W-1:0]           ffe_shift;
    logic [NUM_LANES-1:0][THRESH_W-1:0]              thresh;
    logic [NUM_LANES-1:0][CHAN_LEN-1:0][CHAN_W-1:0]  chan_taps;
    logic [NUM_LANES-1:0][CHAN_SHIFT_W-1:0]          chan_shift;

    logic [NUM_LANES-1:0]             sliced_bits;
    logic [NUM_LANES-1:0][CODE_W-1:0] codes_dly;
    logic                             fill_load;
    logic                             fill_done;

    config_regs #(.NUM_LANES(NUM_LANES)) u_config_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .wr_i         (cfg_wr_i),
        .addr_i       (cfg_addr_i),
        .lane_i       (cfg_lane_i),
        .tap_i        (cfg_tap_i),
        .data_i       (cfg_data_i),
        .weights_o    (weights),
        .disable_o    (ffe_disable),
        .ffe_shift_o  (ffe_shift),
        .thresh_o     (thresh),
        .chan_taps_o  (chan_taps),
        .chan_shift_o (chan_shift)
    );

    startup_fsm u_startup_fsm (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .cfg_wr_i    (cfg_wr_i),
        .fill_done_i (fill_done),
        .fill_load_o (fill_load),
        .valid_o     (valid_o)
    );

    fill_counter u_fill_counter (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (fill_load),
        .done_o  (fill_done)
    );

    // Word n in, bits for word n out at n+1
    ffe_slicer #(.NUM_LANES(NUM_LANES)) u_ffe_slicer (
        .clk         (clk),
        .reset_i     (reset_i),
        .codes_i     (adc_codes_i),
        .weights_i   (weights),
        .disable_i   (ffe_disable),
        .ffe_shift_i (ffe_shift),
        .thresh_i    (thresh),
        .bits_o      (sliced_bits)
    );

    // ADC word aligned with the sliced bits
    code_delay_line #(.NUM_LANES(NUM_LANES), .WIDTH(CODE_W), .DEPTH(1)) u_code_dly (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (adc_codes_i),
        .data_o  (codes_dly)
    );

    channel_error #(.NUM_LANES(NUM_LANES)) u_channel_error (
        .clk          (clk),
        .reset_i      (reset_i),
        .bits_i       (sliced_bits),
        .codes_i      (codes_dly),
        .chan_taps_i  (chan_taps),
        .chan_shift_i (chan_shift),
        .error_o      (error_o)
    );

    // Bits held one more cycle to line up with error_o
    code_delay_line #(.NUM_LANES(NUM_LANES), .WIDTH(1), .DEPTH(1)) u_bits_dly (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (sliced_bits),
        .data_o  (bits_o)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released just after a rising edge, like the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

/* verification/dsp_datapath_tb.sv */
`timescale 1ns/1ps

module dsp_datapath_tb;
    import dsp_pkg::*;

    localparam int NUM_LANES   = 4;
    localparam int LANE_W      = $clog2(NUM_LANES);
    localparam int SEED        = 99049;
    localparam int MIN_CHECKED = 100;
    localparam int VALID_WAIT  = PIPE_FILL + 4;

    logic                             clk;
    logic                             reset;
    logic [NUM_LANES-1:0][CODE_W-1:0] adc_codes;
    logic                             start;
    logic                             cfg_wr;
    cfg_addr_t                        cfg_addr;
    logic [LANE_W-1:0]                cfg_lane;
    logic [CFG_TAP_W-1:0]             cfg_tap;
    logic [CFG_DATA_W-1:0]            cfg_data;
    logic [NUM_LANES-1:0]             dut_bits;
    logic [NUM_LANES-1:0][ERR_W-1:0]  dut_error;
    logic                             dut_valid;

    // Shadow of the register bank
    logic signed [WEIGHT_W-1:0] m_weight [NUM_LANES][FFE_LEN];
    logic                       m_disable [NUM_LANES][FFE_LEN];
    logic [FFE_SHIFT_W-1:0]     m_ffe_shift [NUM_LANES];
    logic signed [THRESH_W-1:0] m_thresh [NUM_LANES];
    logic signed [CHAN_W-1:0]   m_chan [NUM_LANES][CHAN_LEN];
    logic [CHAN_SHIFT_W-1:0]    m_chan_shift [NUM_LANES];

    logic [NUM_LANES-1:0][CODE_W-1:0] last_word;
    logic [NUM_LANES-1:0]             stage_bits;
    logic [NUM_LANES-1:0]             stage_bits_prev;
    logic [NUM_LANES-1:0]             exp_bits;
    logic [NUM_LANES-1:0][ERR_W-1:0]  exp_error;

    logic started;
    int   fill_age;
    logic valid_expected;
    int   checked_cycles = 0;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    dsp_datapath_top #(.NUM_LANES(NUM_LANES)) u_dut (
        .clk         (clk),
        .reset_i     (reset),
        .adc_codes_i (adc_codes),
        .start_i     (start),
        .cfg_wr_i    (cfg_wr),
        .cfg_addr_i  (cfg_addr),
        .cfg_lane_i  (cfg_lane),
        .cfg_tap_i   (cfg_tap),
        .cfg_data_i  (cfg_data),
        .bits_o      (dut_bits),
        .error_o     (dut_error),
        .valid_o     (dut_valid)
    );

    // Sample order in time runs from lane 0 of the previous word to the top lane of cur
    function automatic logic [NUM_LANES-1:0] slice_word(
        input logic [NUM_LANES-1:0][CODE_W-1:0] cur,
        input logic [NUM_LANES-1:0][CODE_W-1:0] prev
    );
        logic [NUM_LANES-1:0]    result;
        logic signed [EST_W-1:0] est;
        int                      sum;
        int                      sample;
        int                      s;
        result = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            sum = 0;
            for (int k = 0; k < FFE_LEN; k++) begin
                s = l - k;
                if (s >= 0) begin
                    sample = $signed(cur[s]);
                end else begin
                    sample = $signed(prev[NUM_LANES+s]);
                end
                if (!m_disable[l][k]) begin
                    sum = sum + sample * int'(m_weight[l][k]);
                end
            end
            sum = sum >>> m_ffe_shift[l];
            est = sum[EST_W-1:0];
            result[l] = (est >= m_thresh[l]);
        end
        return result;
    endfunction

    function automatic logic [NUM_LANES-1:0][ERR_W-1:0] expect_error(
        input logic [NUM_LANES-1:0]             cur_bits,
        input logic [NUM_LANES-1:0]             prev_bits,
        input logic [NUM_LANES-1:0][CODE_W-1:0] codes
    );
        logic [NUM_LANES-1:0][ERR_W-1:0] result;
        logic                            b;
        int                              acc;
        int                              s;
        int                              diff;
        for (int l = 0; l < NUM_LANES; l++) begin
            acc = 0;
            for (int k = 0; k < CHAN_LEN; k++) begin
                s = l - k;
                b = (s >= 0) ? cur_bits[s] : prev_bits[NUM_LANES+s];
                acc = b ? acc + int'(m_chan[l][k]) : acc - int'(m_chan[l][k]);
            end
            acc = acc >>> m_chan_shift[l];
            diff = acc - int'($signed(codes[l]));
            result[l] = ERR_W'(diff);
        end
        return result;
    endfunction

    // Reference pipeline, two stages like the datapath
    always @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int k = 0; k < FFE_LEN; k++) begin
                    m_weight[l][k]  <= '0;
                    m_disable[l][k] <= 1'b0;
                end
                for (int k = 0; k < CHAN_LEN; k++) begin
                    m_chan[l][k] <= '0;
                end
                m_ffe_shift[l]  <= '0;
                m_thresh[l]     <= '0;
                m_chan_shift[l] <= '0;
            end
            last_word       <= '0;
            stage_bits      <= '0;
            stage_bits_prev <= '0;
            exp_bits        <= '0;
            exp_error       <= '0;
        end else begin
            stage_bits      <= slice_word(adc_codes, last_word);
            last_word       <= adc_codes;
            stage_bits_prev <= stage_bits;
            exp_bits        <= stage_bits;
            exp_error       <= expect_error(stage_bits, stage_bits_prev, last_word);
            if (cfg_wr) begin
                case (cfg_addr)
                    CFG_WEIGHT:     m_weight[cfg_lane][cfg_tap]  <= cfg_data[WEIGHT_W-1:0];
                    CFG_DISABLE:    m_disable[cfg_lane][cfg_tap] <= cfg_data[0];
                    CFG_FFE_SHIFT:  m_ffe_shift[cfg_lane]        <= cfg_data[FFE_SHIFT_W-1:0];
                    CFG_THRESH:     m_thresh[cfg_lane]           <= cfg_data[THRESH_W-1:0];
                    CFG_CHAN_TAP:   m_chan[cfg_lane][cfg_tap]    <= cfg_data[CHAN_W-1:0];
                    CFG_CHAN_SHIFT: m_chan_shift[cfg_lane]       <= cfg_data[CHAN_SHIFT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Cycles since the last strobe that restarts the refill
    always @(posedge clk) begin
        if (reset) begin
            started  <= 1'b0;
            fill_age <= 0;
        end else if ((start && !started) || (cfg_wr && started)) begin
            started  <= 1'b1;
            fill_age <= 0;
        end else if (fill_age < PIPE_FILL) begin
            fill_age <= fill_age + 1;
        end
        if (!reset && dut_valid) begin
            checked_cycles <= checked_cycles + 1;
        end
    end

    assign valid_expected = started && (fill_age >= PIPE_FILL);

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
        $display("Done: errors found");
        $fatal(1, "%s check failed", name);
    endtask

    a_quiet_before_start: assert property (
        @(posedge clk) disable iff (reset) !started |-> !dut_valid
    ) else report_mismatch("valid_o", 64'($sampled(dut_valid)), 64'(0));

    a_valid_timing: assert property (
        @(posedge clk) disable iff (reset) started |-> (dut_valid == valid_expected)
    ) else report_mismatch("valid_o", 64'($sampled(dut_valid)), 64'($sampled(valid_expected)));

    a_bits_match: assert property (
        @(posedge clk) disable iff (reset) dut_valid |-> (dut_bits == exp_bits)
    ) else report_mismatch("bits_o", 64'($sampled(dut_bits)), 64'($sampled(exp_bits)));

    a_error_match: assert property (
        @(posedge clk) disable iff (reset) dut_valid |-> (dut_error == exp_error)
    ) else report_mismatch("error_o", 64'($sampled(dut_error)), 64'($sampled(exp_error)));

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "%s", reason);
    endtask

    // Fresh ADC word every cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        for (int l = 0; l < NUM_LANES; l++) begin
            adc_codes[l] = CODE_W'($urandom);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_reg(input cfg_addr_t addr, input int lane, input int tap,
                             input int data);
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_lane = LANE_W'(lane);
        cfg_tap  = CFG_TAP_W'(tap);
        cfg_data = CFG_DATA_W'(data);
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    // Reset is looked at on the rising edge, where it is stable
    task automatic wait_for_reset_release(input int max_cycles);
        int waited;
        waited = 0;
        @(posedge clk);
        while (reset !== 1'b0) begin
            if (waited >= max_cycles) begin
                abort_run("timeout: reset was never released");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        #1;
    endtask

    task automatic wait_for_valid(input int max_cycles);
        int waited;
        waited = 0;
        while (!dut_valid) begin
            if (waited >= max_cycles) begin
                abort_run("timeout: valid_o did not rise after the refill");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic randomize_ffe();
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < FFE_LEN; k++) begin
                write_reg(CFG_WEIGHT, l, k, int'($urandom_range(0, 63)));
            end
            write_reg(CFG_FFE_SHIFT, l, 0, int'($urandom_range(0, 7)));
            write_reg(CFG_THRESH, l, 0, int'($urandom_range(0, 255)) - 128);
        end
    endtask

    task automatic randomize_channel();
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < CHAN_LEN; k++) begin
                write_reg(CFG_CHAN_TAP, l, k, int'($urandom_range(0, 255)));
            end
            write_reg(CFG_CHAN_SHIFT, l, 0, int'($urandom_range(0, 3)));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        adc_codes = '0;
        start     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = CFG_WEIGHT;
        cfg_lane  = '0;
        cfg_tap   = '0;
        cfg_data  = '0;
        wait_for_reset_release(40);

        // Writes while idle leave the pipeline stopped
        randomize_ffe();
        randomize_channel();
        idle_cycles(8);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        wait_for_valid(VALID_WAIT);
        idle_cycles(24);

        for (int k = 0; k < FFE_LEN; k++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                write_reg(CFG_DISABLE, l, k, 1);
            end
            wait_for_valid(VALID_WAIT);
            idle_cycles(16);
            randomize_ffe();
            wait_for_valid(VALID_WAIT);
            idle_cycles(16);
            for (int l = 0; l < NUM_LANES; l++) begin
                write_reg(CFG_DISABLE, l, k, 0);
            end
            wait_for_valid(VALID_WAIT);
            idle_cycles(8);
        end

        for (int r = 0; r < 6; r++) begin
            randomize_channel();
            wait_for_valid(VALID_WAIT);
            idle_cycles(20);
        end

        // Lone write in RUN, then a second one in the middle of the refill
        write_reg(CFG_THRESH, 1, 0, -40);
        wait_for_valid(VALID_WAIT);
        idle_cycles(12);
        write_reg(CFG_CHAN_SHIFT, 2, 0, 3);
        next_cycle();
        write_reg(CFG_WEIGHT, 3, 2, 31);
        wait_for_valid(VALID_WAIT);
        idle_cycles(20);

        if (checked_cycles < MIN_CHECKED) begin
            $display("only %0d valid cycles were checked", checked_cycles);
            $display("Done: errors found");
            $fatal(1, "too few checked cycles");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* dsp_datapath_top.f */
source/dsp_pkg.sv
source/code_delay_line.sv
source/ffe_slicer.sv
source/channel_error.sv
source/config_regs.sv
source/fill_counter.sv
source/startup_fsm.sv
source/dsp_datapath_top.sv
verification/tb_clock_gen.sv
verification/dsp_datapath_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := dsp_datapath_tb
FILELIST  := dsp_datapath_top.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
